/* compile.f */
+incdir+rtl
rtl/s16_pkg.sv
rtl/s16_mem_map.sv
rtl/s16_cab_io.sv
rtl/s16_ppi.sv
rtl/s16_cpu_ctrl.sv
rtl/s16_main.sv
tb/tb_s16_main.sv

/* Makefile */
# Verilator build and run of the System 16A bus glue testbench

SRCS = compile.f $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

obj_dir/Vtb_s16_main: $(SRCS)
	verilator --binary --timing --top-module tb_s16_main -f compile.f -o Vtb_s16_main

run: obj_dir/Vtb_s16_main
	./obj_dir/Vtb_s16_main | tee /dev/stderr | grep -q "^All tests passed!$$"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* tb/tb_s16_main.sv */
// Testbench for the System 16A bus glue
// random 68000 bus master, memory responders and a reference model

`include "s16_params.svh"

module tb_s16_main;

    localparam int n_bus   = 300 + 80 + 66 + 4;  // bus cycles issued by all tests
    localparam int timeout = (n_bus * 200 + 20 * int'(`S16_CEN_DEN) + 2000) * 10;

    logic clk, rst, as_n, uds_n, lds_n, rnw, service, dip_test, vint, snd_ack;
    logic rom_ok = 1'b0;
    logic ram_ok = 1'b0;
    logic dtack_n, cpu_cen, rom_cs, ram_cs, vram_cs, uds_wn, lds_wn, char_cs, pal_cs, objram_cs;
    logic irq_n, snd_irqn, flip, video_en, sound_en, colscr_en, rowscr_en;
    logic [2:0] fc;
    logic [3:0] start_button;
    logic [1:0] coin_input;
    logic [17:1] rom_addr;
    s16_pkg::game_id_t game_id;
    s16_pkg::cpu_addr_t addr;
    s16_pkg::bus_word_t wdata, rdata, rom_data, ram_data, char_dout, pal_dout, obj_dout;
    s16_pkg::port_byte_t joystick1, joystick2, joystick3, joystick4, dipsw_a, dipsw_b;
    s16_pkg::port_byte_t snd_latch;

    // reference model state, PPI dirs use 1 = input
    logic dir_a, dir_b, dir_ch, dir_cl;
    s16_pkg::port_byte_t la, lb, lc;
    logic [1:0] cnt_m;
    int errors, ok_delay, ok_cnt;

    s16_main i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(timeout);
        $display("timeout: the bus master stopped getting DTACK");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    // ROM/RAM answer after a random number of cycles
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_ok <= 1'b0;
            ram_ok <= 1'b0;
            ok_cnt = 0;
        end else if (rom_cs || ram_cs || vram_cs) begin
            rom_ok <= rom_cs && ok_cnt >= ok_delay;
            ram_ok <= (ram_cs || vram_cs) && ok_cnt >= ok_delay;
            ok_cnt = ok_cnt + 1;
        end else begin
            rom_ok <= 1'b0;
            ram_ok <= 1'b0;
            ok_cnt = 0;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("Test failures found");
            $fatal(1, "check failed");
        end
    endtask

    function automatic s16_pkg::port_byte_t sorted(input s16_pkg::port_byte_t j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    function automatic s16_pkg::port_byte_t pass_order(input s16_pkg::port_byte_t j);
        return {j[7], j[6], j[5], j[4], j[1], j[0], j[3], j[2]};
    endfunction

    function automatic s16_pkg::port_byte_t ppi_read(input logic [1:0] port);
        case (port)
            2'd0: return dir_a ? 8'hff : la;
            2'd1: return dir_b ? 8'hff : lb;
            2'd2: return {dir_ch ? {1'b1, snd_ack, 2'b11} : lc[7:4], dir_cl ? 4'hf : lc[3:0]};
            default: return 8'hff;
        endcase
    endfunction

    function automatic s16_pkg::cpu_addr_t make_addr(input int region, input logic [1:0] sub,
                                                    input logic [1:0] port);
        logic [31:0] r;
        s16_pkg::cpu_addr_t a;
        r = $urandom();
        a = r[22:0];
        case (region)
            0: begin  // ROM
                a[23:22] = 2'd0;
                a[18]    = 1'b0;
            end
            1: begin  // VRAM
                a[22]    = 1'b1;
                a[18:16] = 3'd0;
            end
            2: begin  // char
                a[22]    = 1'b1;
                a[18:16] = 3'd1;
            end
            3: begin  // object RAM
                a[23:22] = 2'd1;
                a[18]    = 1'b1;
            end
            4: begin  // palette
                a[23:22] = 2'd2;
                a[18]    = 1'b1;
            end
            5: begin
                a[23:22] = 2'd3;
                a[18:17] = 2'd2;
                a[13:12] = sub;
                a[2:1]   = port;
            end
            default: begin  // work RAM
                a[23:22] = 2'd3;
                a[18:16] = 3'd7;
            end
        endcase
        return a;
    endfunction

    // one 68000 cycle, held until DTACK
    task automatic bus_cycle(input s16_pkg::cpu_addr_t a, input logic rd,
                             input s16_pkg::bus_word_t wd, input logic [2:0] f,
                             output s16_pkg::bus_word_t data, output logic [1:0] oks,
                             output logic [5:0] sels);
        logic [31:0] r;
        logic [1:0] st;
        @(posedge clk);
        r = $urandom();
        rom_data <= r[15:0];
        ram_data <= r[31:16];
        r = $urandom();
        char_dout <= r[15:0];
        pal_dout  <= r[31:16];
        r = $urandom();
        obj_dout <= r[15:0];
        ok_delay = $urandom() % 6;
        st = 2'($urandom() % 3);  // upper, lower or both strobes
        addr  <= a;
        rnw   <= rd;
        wdata <= wd;
        fc    <= f;
        as_n  <= 1'b0;
        uds_n <= st[1];
        lds_n <= st[0];
        @(negedge clk);
        while (dtack_n)
            @(negedge clk);
        data = rdata;
        oks  = {rom_ok, ram_ok};
        sels = {rom_cs, vram_cs, char_cs, objram_cs, pal_cs, ram_cs};
        check("rom_addr", 32'(a[17:1]), 32'(rom_addr));
        check("uds_wn", 32'(rd | st[1]), 32'(uds_wn));
        check("lds_wn", 32'(rd | st[0]), 32'(lds_wn));
        @(posedge clk);
        as_n  <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        fc    <= 3'b101;
        @(posedge clk);
    endtask

    // expected cabinet byte, advances the player counter like a new access
    task automatic cab_expect(input logic [1:0] sub, input logic [1:0] port,
                              output s16_pkg::port_byte_t e);
        logic pass;
        pass = game_id == `S16_GAME_PASSSHT;
        e = 8'hff;
        if (sub == 2'd0)
            e = ppi_read(port);
        else if (sub == 2'd2)
            e = port[0] ? dipsw_b : dipsw_a;
        else if (sub == 2'd1 && port == 2'd0) begin
            cnt_m = 2'd0;
            e = {pass ? start_button[3:2] : 2'b11, start_button[1:0], service, dip_test,
                 coin_input};
        end else if (sub == 2'd1 && port == 2'd1 && pass) begin
            cnt_m = cnt_m + 2'd1;
            case (cnt_m)
                2'd1: e = pass_order(joystick1);
                2'd2: e = pass_order(joystick2);
                2'd3: e = pass_order(joystick3);
                default: e = pass_order(joystick4);
            endcase
        end else if (sub == 2'd1 && port == 2'd1)
            e = sorted(joystick1);
        else if (sub == 2'd1 && port == 2'd3)
            e = sorted(joystick2);
    endtask

    task automatic mem_read(input int region, input logic [1:0] sub, input logic [1:0] port,
                            input string name);
        s16_pkg::cpu_addr_t a;
        s16_pkg::bus_word_t d, exp;
        s16_pkg::port_byte_t e8;
        logic [1:0] oks;
        logic [5:0] sels, exp_sel;
        a = make_addr(region, sub, port);
        bus_cycle(a, 1'b1, 16'h0000, 3'b101, d, oks, sels);
        e8 = 8'hff;
        if (region == 5)
            cab_expect(sub, port, e8);
        case (region)
            0: exp = rom_data;
            2: exp = char_dout;
            3: exp = obj_dout;
            4: exp = pal_dout;
            5: exp = {8'hff, e8};
            default: exp = ram_data;
        endcase
        check(name, 32'(exp), 32'(d));
        // selects in region order, I/O has none outside
        exp_sel = region == 5 ? 6'd0 : 6'b100000 >> (region < 5 ? region : region - 1);
        check("chip selects", 32'(exp_sel), 32'(sels));
        if (region == 0)
            check("rom_ok before dtack", 32'(1), 32'(oks[1]));
        else if (region == 1 || region == 6)
            check("ram_ok before dtack", 32'(1), 32'(oks[0]));
    endtask

    task automatic rand_inputs();
        logic [31:0] r;
        @(posedge clk);
        r = $urandom();
        joystick1 <= r[7:0];
        joystick2 <= r[15:8];
        joystick3 <= r[23:16];
        joystick4 <= r[31:24];
        r = $urandom();
        dipsw_a      <= r[7:0];
        dipsw_b      <= r[15:8];
        start_button <= r[19:16];
        coin_input   <= r[21:20];
        service      <= r[22];
        dip_test     <= r[23];
        snd_ack      <= r[24];
    endtask

    task automatic check_pins();
        s16_pkg::port_byte_t pb, pc;
        pb = dir_b ? 8'hff : lb;
        pc = {dir_ch ? 4'hf : lc[7:4], dir_cl ? 4'hf : lc[3:0]};
        check("snd_latch", 32'(dir_a ? 8'hff : la), 32'(snd_latch));
        check("flip", 32'(pb[7]), 32'(flip));
        check("sound_en", 32'(!pb[5]), 32'(sound_en));
        check("video_en", 32'(pb[4]), 32'(video_en));
        check("snd_irqn", 32'(pc[7]), 32'(snd_irqn));
        check("colscr_en", 32'(!pc[2]), 32'(colscr_en));
        check("rowscr_en", 32'(!pc[1]), 32'(rowscr_en));
    endtask

    task automatic ppi_op();
        logic [31:0] r;
        s16_pkg::bus_word_t d;
        logic [1:0] oks;
        logic [5:0] sels;
        s16_pkg::port_byte_t w;
        r = $urandom();
        w = r[7:0];
        bus_cycle(make_addr(5, 2'd0, r[9:8]), 1'b0, {r[31:24], w}, 3'b101, d, oks, sels);
        case (r[9:8])
            2'd0: la = w;
            2'd1: lb = w;
            2'd2: lc = w;
            default: begin
                if (w[7]) begin  // mode word
                    dir_a  = w[4];
                    dir_ch = w[3];
                    dir_b  = w[1];
                    dir_cl = w[0];
                    la = 8'h00;
                    lb = 8'h00;
                    lc = 8'h00;
                end else
                    lc[w[3:1]] = w[0];
            end
        endcase
        @(negedge clk);
        check_pins();
    endtask

    initial begin
        s16_pkg::bus_word_t d;
        logic [1:0] oks;
        logic [5:0] sels;
        logic prev;
        int cnt;
        void'($urandom(32'h1fbf_8a4a));
        errors = 0;
        {rst, rnw, as_n, uds_n, lds_n} = 5'b11111;
        {vint, snd_ack, service, dip_test, start_button, coin_input} = '0;
        {fc, game_id, addr, wdata} = {3'b101, 8'h00, 23'h0, 16'h0};
        {rom_data, ram_data, char_dout, pal_dout, obj_dout} = '0;
        {joystick1, joystick2, joystick3, joystick4, dipsw_a, dipsw_b} = '0;
        {dir_a, dir_b, dir_ch, dir_cl, la, lb, lc, cnt_m} = {4'hf, 24'h0, 2'd0};
        ok_delay = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_pins();
        check("reset irq_n", 32'(1), 32'(irq_n));
        check("reset dtack_n", 32'(1), 32'(dtack_n));
        check("reset rdata", 32'hffff, 32'(rdata));

        rand_inputs();
        for (int i = 0; i < 300; i++)
            mem_read(int'($urandom() % 7), 2'($urandom()), 2'($urandom()), "random read");

        for (int g = 0; g < 2; g++) begin
            @(posedge clk);
            game_id <= g == 1 ? `S16_GAME_PASSSHT : 8'h00;
            repeat (4) begin
                rand_inputs();
                mem_read(5, 2'd1, 2'd0, "system port");
                repeat (5) mem_read(5, 2'd1, 2'd1, "player port");
                mem_read(5, 2'd1, 2'd3, "joystick 2 port");
                mem_read(5, 2'd2, 2'd0, "dip a");
                mem_read(5, 2'd2, 2'd1, "dip b");
                mem_read(5, 2'd1, 2'd2, "unused port");
            end
        end

        repeat (6) begin
            rand_inputs();
            repeat (10) ppi_op();
            mem_read(5, 2'd0, 2'd2, "ppi port c read");
        end

        repeat (4) begin
            repeat ($urandom() % 10) @(posedge clk);
            vint <= 1'b1;
            @(posedge clk);
            vint <= 1'b0;
            @(negedge clk);
            check("irq_n after vint", 32'(0), 32'(irq_n));
            repeat ($urandom() % 20) @(posedge clk);
            @(negedge clk);
            check("irq_n held", 32'(0), 32'(irq_n));
            bus_cycle(make_addr(0, 2'd0, 2'd0), 1'b1, 16'h0000, 3'b111, d, oks, sels);
            @(negedge clk);
            check("irq_n after ack", 32'(1), 32'(irq_n));
        end

        cnt = 0;
        prev = 1'b0;
        repeat (20 * int'(`S16_CEN_DEN)) begin
            @(negedge clk);
            check("cpu_cen adjacent", 32'(0), 32'(cpu_cen & prev));
            if (cpu_cen)
                cnt++;
            prev = cpu_cen;
        end
        check("cpu_cen count", 32'(20 * int'(`S16_CEN_NUM)), 32'(cnt));

        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* rtl/s16_main.sv */
// System 16A main board bus glue
// connects the outside 68000 bus to the memory map, cabinet I/O,
// 8255 PPI and CPU control blocks

module s16_main (
    input  logic                clk,
    input  logic                rst,
    input  s16_pkg::game_id_t   game_id,
    input  s16_pkg::cpu_addr_t  addr,
    input  logic                as_n,
    input  logic                uds_n,
    input  logic                lds_n,
    input  logic                rnw,
    input  logic [2:0]          fc,
    input  s16_pkg::bus_word_t  wdata,
    output s16_pkg::bus_word_t  rdata,
    output logic                dtack_n,
    output logic                cpu_cen,
    output logic                irq_n,
    output logic                rom_cs,
    output logic                ram_cs,
    output logic                vram_cs,
    output logic [17:1]         rom_addr,
    output logic                uds_wn,
    output logic                lds_wn,
    input  s16_pkg::bus_word_t  rom_data,
    input  s16_pkg::bus_word_t  ram_data,
    input  logic                rom_ok,
    input  logic                ram_ok,
    output logic                char_cs,
    output logic                pal_cs,
    output logic                objram_cs,
    input  s16_pkg::bus_word_t  char_dout,
    input  s16_pkg::bus_word_t  pal_dout,
    input  s16_pkg::bus_word_t  obj_dout,
    input  s16_pkg::port_byte_t joystick1,
    input  s16_pkg::port_byte_t joystick2,
    input  s16_pkg::port_byte_t joystick3,
    input  s16_pkg::port_byte_t joystick4,
    input  logic [3:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic                service,
    input  logic                dip_test,
    input  s16_pkg::port_byte_t dipsw_a,
    input  s16_pkg::port_byte_t dipsw_b,
    input  logic                vint,
    input  logic                snd_ack,
    output s16_pkg::port_byte_t snd_latch,
    output logic                snd_irqn,
    output logic                flip,
    output logic                video_en,
    output logic                sound_en,
    output logic                colscr_en,
    output logic                rowscr_en
);

    logic                io_cs, ppi_cs, bus_cs, bus_busy;
    s16_pkg::port_byte_t cab_dout, ppi_dout, ppib_dout, ppic_dout, ppic_din;

    assign uds_wn   = rnw | uds_n;
    assign lds_wn   = rnw | lds_n;
    assign rom_addr = addr[17:1];  // 256 kB program ROM

    assign ppic_din = {1'b1, snd_ack, 6'h3f};
    assign flip      = ppib_dout[7];
    assign sound_en  = ~ppib_dout[5];
    assign video_en  = ppib_dout[4];
    assign snd_irqn  = ppic_dout[7];
    assign colscr_en = ~ppic_dout[2];
    assign rowscr_en = ~ppic_dout[1];

    s16_mem_map i_mem_map (
        .clk(clk), .rst(rst), .addr(addr), .as_n(as_n), .uds_n(uds_n), .lds_n(lds_n),
        .rom_data(rom_data), .ram_data(ram_data), .char_dout(char_dout),
        .pal_dout(pal_dout), .obj_dout(obj_dout), .cab_dout(cab_dout),
        .rom_ok(rom_ok), .ram_ok(ram_ok), .rom_cs(rom_cs), .ram_cs(ram_cs),
        .vram_cs(vram_cs), .char_cs(char_cs), .pal_cs(pal_cs), .objram_cs(objram_cs),
        .io_cs(io_cs), .bus_cs(bus_cs), .bus_busy(bus_busy), .rdata(rdata)
    );

    s16_cab_io i_cab_io (
        .clk(clk), .rst(rst), .io_cs(io_cs), .as_n(as_n),
        .addr_io({addr[13:12], addr[2:1]}), .game_id(game_id),
        .joystick1(joystick1), .joystick2(joystick2), .joystick3(joystick3),
        .joystick4(joystick4), .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .ppi_dout(ppi_dout), .ppi_cs(ppi_cs), .cab_dout(cab_dout)
    );

    s16_ppi i_ppi (
        .clk(clk), .rst(rst), .cs(ppi_cs), .rnw(rnw), .port_addr(addr[2:1]),
        .din(wdata[7:0]), .portc_din(ppic_din), .dout(ppi_dout),
        .porta_dout(snd_latch), .portb_dout(ppib_dout), .portc_dout(ppic_dout)
    );

    s16_cpu_ctrl i_cpu_ctrl (
        .clk(clk), .rst(rst), .bus_cs(bus_cs), .bus_busy(bus_busy), .as_n(as_n),
        .vint(vint), .fc(fc), .cpu_cen(cpu_cen), .dtack_n(dtack_n), .irq_n(irq_n)
    );

endmodule

/* rtl/s16_cpu_ctrl.sv */
// CPU control
// fractional clock enable, DTACK with ROM/RAM wait states
// and the VBLANK interrupt level

`include "s16_params.svh"

module s16_cpu_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       bus_cs,
    input  logic       bus_busy,
    input  logic       as_n,
    input  logic       vint,
    input  logic [2:0] fc,
    output logic       cpu_cen,
    output logic       dtack_n,
    output logic       irq_n
);

    logic [7:0] acc;
    logic [8:0] acc_sum;
    logic       last_vint;
    logic       inta;     // interrupt acknowledge cycle

    assign acc_sum = {1'b0, acc} + {1'b0, `S16_CEN_NUM};
    assign inta    = &fc & ~as_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc     <= 8'd0;
            cpu_cen <= 1'b0;
        end else if (acc_sum >= {1'b0, `S16_CEN_DEN}) begin
            acc     <= 8'(acc_sum - {1'b0, `S16_CEN_DEN});
            cpu_cen <= 1'b1;
        end else begin
            acc     <= acc_sum[7:0];
            cpu_cen <= 1'b0;
        end
    end

    // held low until the master drops AS
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            dtack_n <= 1'b1;
        else if (as_n)
            dtack_n <= 1'b1;
        else if (bus_cs && !bus_busy)
            dtack_n <= 1'b0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_vint <= 1'b0;
            irq_n     <= 1'b1;
        end else begin
            last_vint <= vint;
            if (inta)
                irq_n <= 1'b1;
            else if (vint && !last_vint)
                irq_n <= 1'b0;  // VBLANK, level 4
        end
    end

endmodule

/* rtl/s16_ppi.sv */
// 8255 PPI, mode 0 only
// control word, port C bit set/reset and three latched ports

module s16_ppi (
    input  logic                clk,
    input  logic                rst,
    input  logic                cs,
    input  logic                rnw,
    input  logic [1:0]          port_addr,
    input  s16_pkg::port_byte_t din,
    input  s16_pkg::port_byte_t portc_din,
    output s16_pkg::port_byte_t dout,
    output s16_pkg::port_byte_t porta_dout,
    output s16_pkg::port_byte_t portb_dout,
    output s16_pkg::port_byte_t portc_dout
);

    s16_pkg::ppi_dir_t   dir_a, dir_b, dir_ch, dir_cl;
    s16_pkg::port_byte_t latch_a, latch_b, latch_c;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dir_a   <= s16_pkg::port_in;
            dir_b   <= s16_pkg::port_in;
            dir_ch  <= s16_pkg::port_in;
            dir_cl  <= s16_pkg::port_in;
            latch_a <= 8'h00;
            latch_b <= 8'h00;
            latch_c <= 8'h00;
        end else if (cs && !rnw) begin
            case (port_addr)
                2'd0: latch_a <= din;
                2'd1: latch_b <= din;
                2'd2: latch_c <= din;
                default: begin
                    if (din[7]) begin  // mode set, latches cleared
                        dir_a   <= s16_pkg::ppi_dir_t'(din[4]);
                        dir_ch  <= s16_pkg::ppi_dir_t'(din[3]);
                        dir_b   <= s16_pkg::ppi_dir_t'(din[1]);
                        dir_cl  <= s16_pkg::ppi_dir_t'(din[0]);
                        latch_a <= 8'h00;
                        latch_b <= 8'h00;
                        latch_c <= 8'h00;
                    end else begin
                        latch_c[din[3:1]] <= din[0];  // bit set/reset
                    end
                end
            endcase
        end
    end

    // input pins float high on the board side
    assign porta_dout = dir_a == s16_pkg::port_in ? 8'hff : latch_a;
    assign portb_dout = dir_b == s16_pkg::port_in ? 8'hff : latch_b;
    assign portc_dout[7:4] = dir_ch == s16_pkg::port_in ? 4'hf : latch_c[7:4];
    assign portc_dout[3:0] = dir_cl == s16_pkg::port_in ? 4'hf : latch_c[3:0];

    always_comb begin
        case (port_addr)
            2'd0: dout = dir_a == s16_pkg::port_out ? latch_a : 8'hff;  // no A pins
            2'd1: dout = dir_b == s16_pkg::port_out ? latch_b : 8'hff;
            2'd2: begin
                dout[7:4] = dir_ch == s16_pkg::port_out ? latch_c[7:4] : portc_din[7:4];
                dout[3:0] = dir_cl == s16_pkg::port_out ? latch_c[3:0] : portc_din[3:0];
            end
            default: dout = 8'hff;
        endcase
    end

endmodule

/* rtl/s16_cab_io.sv */
// Cabinet I/O block
// input ports, DIP switches and PPI access inside the I/O region,
// with the four-player port counter of Passing Shot

`include "s16_params.svh"

module s16_cab_io (
    input  logic                clk,
    input  logic                rst,
    input  logic                io_cs,
    input  logic                as_n,
    input  logic [3:0]          addr_io,     // A13..A12, A2..A1
    input  s16_pkg::game_id_t   game_id,
    input  s16_pkg::port_byte_t joystick1,
    input  s16_pkg::port_byte_t joystick2,
    input  s16_pkg::port_byte_t joystick3,
    input  s16_pkg::port_byte_t joystick4,
    input  logic [3:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic                service,
    input  logic                dip_test,
    input  s16_pkg::port_byte_t dipsw_a,
    input  s16_pkg::port_byte_t dipsw_b,
    input  s16_pkg::port_byte_t ppi_dout,
    output logic                ppi_cs,
    output s16_pkg::port_byte_t cab_dout
);

    logic       passsht;
    logic       io_seen;   // current bus cycle already hit the I/O region
    logic       io_new;
    logic [1:0] port_cnt;
    logic [1:0] cnt_sel;   // count shown during this access

    function automatic s16_pkg::port_byte_t sort_joy(input s16_pkg::port_byte_t j);
        return {j[1:0], j[3:2], j[7], j[5:4], j[6]};
    endfunction

    function automatic s16_pkg::port_byte_t pass_joy(input s16_pkg::port_byte_t j);
        return {j[7:4], j[1:0], j[3:2]};
    endfunction

    assign passsht = game_id == `S16_GAME_PASSSHT;
    assign io_new  = io_cs & ~io_seen;
    assign cnt_sel = io_seen ? port_cnt : port_cnt + 2'd1;  // stable across the access

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_seen  <= 1'b0;
            port_cnt <= 2'd0;
            ppi_cs   <= 1'b0;
        end else begin
            if (as_n)
                io_seen <= 1'b0;
            else if (io_cs)
                io_seen <= 1'b1;
            ppi_cs <= io_new && addr_io[3:2] == `S16_IO_PPI;  // one pulse per access
            if (io_new && addr_io[3:2] == `S16_IO_CAB) begin
                if (addr_io[1:0] == 2'd0)
                    port_cnt <= 2'd0;
                else if (addr_io[1:0] == 2'd1 && passsht)
                    port_cnt <= port_cnt + 2'd1;
            end
        end
    end

    always_comb begin
        cab_dout = 8'hff;
        if (io_cs) begin
            case (addr_io[3:2])
                `S16_IO_PPI: cab_dout = ppi_dout;
                `S16_IO_CAB: begin
                    case (addr_io[1:0])
                        2'd0: begin
                            cab_dout = {2'b11, start_button[1:0], service, dip_test,
                                        coin_input};
                            if (passsht)
                                cab_dout[7:6] = start_button[3:2];
                        end
                        2'd1: begin
                            if (!passsht)
                                cab_dout = sort_joy(joystick1);
                            else case (cnt_sel)
                                2'd1: cab_dout = pass_joy(joystick1);
                                2'd2: cab_dout = pass_joy(joystick2);
                                2'd3: cab_dout = pass_joy(joystick3);
                                default: cab_dout = pass_joy(joystick4);
                            endcase
                        end
                        2'd3: cab_dout = sort_joy(joystick2);
                        default: cab_dout = 8'hff;
                    endcase
                end
                `S16_IO_DIP: cab_dout = addr_io[0] ? dipsw_b : dipsw_a;
                default: cab_dout = 8'hff;
            endcase
        end
    end

endmodule

/* rtl/s16_mem_map.sv */
// System 16A memory map
// registered chip selects from the 68000 address and the read data mux

module s16_mem_map (
    input  logic               clk,
    input  logic               rst,
    input  s16_pkg::cpu_addr_t addr,
    input  logic               as_n,
    input  logic               uds_n,
    input  logic               lds_n,
    input  s16_pkg::bus_word_t rom_data,
    input  s16_pkg::bus_word_t ram_data,
    input  s16_pkg::bus_word_t char_dout,
    input  s16_pkg::bus_word_t pal_dout,
    input  s16_pkg::bus_word_t obj_dout,
    input  s16_pkg::port_byte_t cab_dout,
    input  logic               rom_ok,
    input  logic               ram_ok,
    output logic               rom_cs,
    output logic               ram_cs,
    output logic               vram_cs,
    output logic               char_cs,
    output logic               pal_cs,
    output logic               objram_cs,
    output logic               io_cs,
    output logic               bus_cs,
    output logic               bus_busy,
    output s16_pkg::bus_word_t rdata
);

    logic bus_n;  // low when a data strobe is active inside the cycle

    assign bus_n = as_n | (uds_n & lds_n);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
        end else if (!as_n) begin
            rom_cs    <= addr[23:22] == 2'd0 && !addr[18];      // 00-03
            char_cs   <= addr[22] && addr[18:16] == 3'd1;       // 41
            objram_cs <= addr[23:22] == 2'd1 && addr[18];       // 44
            pal_cs    <= addr[23:22] == 2'd2 && addr[18];       // 84
            io_cs     <= addr[23:22] == 2'd3 && addr[18:17] == 2'd2;  // c4
            // strobe qualified so a read-modify-write gives a fresh request
            vram_cs   <= !bus_n && addr[22] && addr[18:16] == 3'd0;   // 40
            ram_cs    <= !bus_n && addr[23:22] == 2'd3 && addr[18:16] == 3'd7;
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
        end
    end

    assign bus_cs   = rom_cs | ram_cs | vram_cs | char_cs | pal_cs | objram_cs | io_cs;
    assign bus_busy = (rom_cs & ~rom_ok) | ((ram_cs | vram_cs) & ~ram_ok);

    // read mux, one cycle behind the selects
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= 16'hffff;
        end else if (ram_cs || vram_cs) begin
            rdata <= ram_data;
        end else if (rom_cs) begin
            rdata <= rom_data;
        end else if (char_cs) begin
            rdata <= char_dout;
        end else if (pal_cs) begin
            rdata <= pal_dout;
        end else if (objram_cs) begin
            rdata <= obj_dout;
        end else if (io_cs) begin
            rdata <= {8'hff, cab_dout};  // cabinet ports are byte wide
        end else begin
            rdata <= 16'hffff;
        end
    end

endmodule

/* rtl/s16_pkg.sv */
// System 16A bus glue types
// vector widths of the 68000 bus and the board ports, plus PPI port direction

package s16_pkg;

    // 68000 word address, A0 is not on the bus
    typedef logic [23:1] cpu_addr_t;

    typedef logic [15:0] bus_word_t;   // data bus word

    typedef logic [7:0] port_byte_t;   // cabinet or PPI port

    typedef logic [7:0] game_id_t;     // board variant

    // 8255 direction, encoded as in the control word (1 = input)
    typedef enum logic {
        port_out = 1'b0,
        port_in  = 1'b1
    } ppi_dir_t;

endpackage

/* rtl/s16_params.svh */
// System 16A board constants
// region codes of the I/O block, game ids and the CPU clock-enable ratio

`ifndef S16_PARAMS_SVH
`define S16_PARAMS_SVH

// board variant codes
`define S16_GAME_PASSSHT 8'h01

// cpu clock enable, NUM pulses every DEN clocks
`define S16_CEN_NUM 8'd29
`define S16_CEN_DEN 8'd146

// I/O sub-regions, selected by A13..A12
`define S16_IO_PPI 2'd0
`define S16_IO_CAB 2'd1
`define S16_IO_DIP 2'd2

`endif
